/* verif/rename_testdata.txt */
# D rd rs1 rs2 src1 src2 dest old stall / C rob_idx / R rd dest old
# All values decimal, stall 1 means ready must be low before acceptance
# Identity sources, first tags from 32, dependent chain, rd 0 takes no tag
D 1 2 3 2 3 32 1 0
D 2 1 0 32 0 33 2 0
D 0 2 1 33 32 0 0 0
D 1 1 2 32 33 34 32 0
R 1 32 1
R 2 33 2
R 0 0 0
R 1 34 32
# Out of order completion, commits still in dispatch order
C 2
C 0
C 3
C 1
# Sixteen destinations drain the free list, reclaimed 1 2 32 come last
D 3 2 1 33 34 35 3 0
D 4 3 1 35 34 36 4 0
D 5 4 1 36 34 37 5 0
D 6 5 1 37 34 38 6 0
D 7 6 1 38 34 39 7 0
D 8 7 1 39 34 40 8 0
D 9 8 1 40 34 41 9 0
D 10 9 1 41 34 42 10 0
D 11 10 1 42 34 43 11 0
D 12 11 1 43 34 44 12 0
D 13 12 1 44 34 45 13 0
D 14 13 1 45 34 46 14 0
D 15 14 1 46 34 47 15 0
D 16 15 1 47 34 1 16 0
D 17 16 1 1 34 2 17 0
D 18 17 1 2 34 32 18 0
# ROB and free list full, this one waits for the oldest to retire
D 19 18 3 32 35 3 19 1
R 3 35 3
C 4

/* all.f */
+incdir+design
design/rename_pkg.sv
design/map_table.sv
design/free_list.sv
design/reorder_buffer.sv
design/rename_core.sv
verif/tb_clock_gen.sv
verif/rename_checker.sv
verif/rename_tb.sv

/* Bender.yml */
package:
  name: rename_core

sources:
  - include_dirs:
      - design
    files:
      - design/rename_pkg.sv
      - design/map_table.sv
      - design/free_list.sv
      - design/reorder_buffer.sv
      - design/rename_core.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/rename_checker.sv
      - verif/rename_tb.sv

/* verif/rename_tb.sv */
/* Testbench top for the rename core. Replays the command file against the
   DUT, waits for every expected result and prints the verdict. */

`timescale 1ns/1ps
`default_nettype none

module rename_tb import rename_pkg::*; ();

    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_LIMIT   = 20;
    localparam int ACCEPT_LIMIT  = 50;
    localparam int DRAIN_LIMIT   = 100;

    logic           clock;
    logic           rst_n;
    logic           dispatch_valid;
    dispatch_inst_t dispatch_inst;
    logic           dispatch_ready;
    logic           complete_valid;
    rob_idx_t       complete_idx;
    logic           rename_valid;
    rename_result_t rename_result;
    logic           commit_valid;
    commit_t        commit;
    int             passes;
    int             fails;
    int             pending;
    logic           aborted;

    tb_clock_gen clock_gen_i (
        .clock (clock),
        .rst_n (rst_n)
    );

    rename_core dut_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_inst  (dispatch_inst),
        .dispatch_ready (dispatch_ready),
        .complete_valid (complete_valid),
        .complete_idx   (complete_idx),
        .rename_valid   (rename_valid),
        .rename_result  (rename_result),
        .commit_valid   (commit_valid),
        .commit         (commit)
    );

    rename_checker checker_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .rename_valid   (rename_valid),
        .rename_result  (rename_result),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .passes         (passes),
        .fails          (fails),
        .pending        (pending)
    );

    // Drop valid after the accepting edge, dispatch may sit across completions
    always @(negedge clock) begin
        if (rst_n && dispatch_valid && dispatch_ready) begin
            @(posedge clock);
            #DRIVE_DELAY;
            dispatch_valid = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Command tasks
    //////////////////////////////////////////////////////////////////////

    task automatic wait_dispatch_idle();
        int cycles;
        cycles = 0;
        while (dispatch_valid && !aborted) begin
            @(negedge clock);
            cycles++;
            if (cycles > ACCEPT_LIMIT) begin
                $display("Timeout: a dispatch was never accepted");
                aborted = 1'b1;
            end
        end
    endtask

    task automatic send_dispatch(input int rd, input int rs1, input int rs2, input int s1,
                                 input int s2, input int dt, input int ot, input int st);
        rename_result_t exp;
        wait_dispatch_idle();
        if (aborted) begin
            return;
        end
        exp.src1_tag = phys_tag_t'(s1);
        exp.src2_tag = phys_tag_t'(s2);
        exp.dest_tag = phys_tag_t'(dt);
        exp.old_tag  = phys_tag_t'(ot);
        exp.has_dest = (rd != 0);
        exp.rob_idx  = '0;
        checker_i.expect_rename(exp, st != 0);
        @(posedge clock);
        #DRIVE_DELAY;
        dispatch_inst.rd  = arch_reg_t'(rd);
        dispatch_inst.rs1 = arch_reg_t'(rs1);
        dispatch_inst.rs2 = arch_reg_t'(rs2);
        dispatch_valid    = 1'b1;
    endtask

    task automatic send_complete(input int idx);
        @(posedge clock);
        #DRIVE_DELAY;
        complete_idx   = rob_idx_t'(idx);
        complete_valid = 1'b1;
        @(posedge clock);
        #DRIVE_DELAY;
        complete_valid = 1'b0;
    endtask

    task automatic queue_commit(input int rd, input int dt, input int ot);
        commit_t exp;
        exp.rd       = arch_reg_t'(rd);
        exp.dest_tag = phys_tag_t'(dt);
        exp.old_tag  = phys_tag_t'(ot);
        exp.has_dest = (rd != 0);
        checker_i.expect_commit(exp);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (pending != 0 && !aborted) begin
            @(posedge clock);
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                $display("Timeout: %0d expected results never came out", pending);
                aborted = 1'b1;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int    fd;
        int    c;
        int    cycles;
        int    rd, rs1, rs2, s1, s2, dt, ot, st;
        string word;
        dispatch_valid = 1'b0;
        dispatch_inst  = '0;
        complete_valid = 1'b0;
        complete_idx   = '0;
        aborted        = 1'b0;
        cycles         = 0;
        while (rst_n !== 1'b1 && !aborted) begin
            @(posedge clock);
            cycles++;
            if (cycles > RESET_LIMIT) begin
                $display("Reset was never released");
                aborted = 1'b1;
            end
        end
        fd = $fopen("verif/rename_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/rename_testdata.txt");
            aborted = 1'b1;
        end else begin
            while (!aborted && $fscanf(fd, "%s", word) == 1) begin
                if (word == "#") begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if (word == "D"
                             && $fscanf(fd, "%d %d %d %d %d %d %d %d",
                                        rd, rs1, rs2, s1, s2, dt, ot, st) == 8) begin
                    send_dispatch(rd, rs1, rs2, s1, s2, dt, ot, st);
                end else if (word == "C" && $fscanf(fd, "%d", rd) == 1) begin
                    send_complete(rd);
                end else if (word == "R" && $fscanf(fd, "%d %d %d", rd, dt, ot) == 3) begin
                    queue_commit(rd, dt, ot);
                end else begin
                    $display("Data file has a malformed command at '%s'", word);
                    aborted = 1'b1;
                end
            end
            $fclose(fd);
        end
        wait_dispatch_idle();
        wait_drain();
        $display("Checks: %0d passed, %0d failed", passes, fails);
        if (aborted || fails != 0) begin
            $display("** FAIL **");
        end else begin
            $display("** PASS **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/rename_checker.sv */
/* Watches the rename core ports and checks each rename result and commit
   record, in order, against the expectations queued by the testbench. */

`timescale 1ns/1ps
`default_nettype none

module rename_checker import rename_pkg::*; (
    input  logic           clock,
    input  logic           rst_n,
    input  logic           dispatch_valid,
    input  logic           dispatch_ready,
    input  logic           rename_valid,
    input  rename_result_t rename_result,
    input  logic           commit_valid,
    input  commit_t        commit,
    output int             passes,
    output int             fails,
    output int             pending
);

    rename_result_t rename_q [$];
    logic           stall_q [$];
    commit_t        commit_q [$];
    int             rename_count = 0;
    int             commit_count = 0;
    logic           accept_d = 1'b0;
    logic           stall_d = 1'b0;
    logic           stall_seen = 1'b0;
    logic           after_reset = 1'b0;

    initial begin
        passes  = 0;
        fails   = 0;
        pending = 0;
    end

    //////////////////////////////////////////////////////////////////////
    // Expectation queues
    //////////////////////////////////////////////////////////////////////

    // Stall flag says whether this dispatch should see ready low first
    task automatic expect_rename(input rename_result_t exp, input logic stall);
        rename_q.push_back(exp);
        stall_q.push_back(stall);
        pending++;
    endtask

    task automatic expect_commit(input commit_t exp);
        commit_q.push_back(exp);
        pending++;
    endtask

    function automatic string show_rename(input rename_result_t r);
        return $sformatf("src %0d/%0d dest %0d old %0d has_dest %0b rob %0d",
                         r.src1_tag, r.src2_tag, r.dest_tag, r.old_tag,
                         r.has_dest, r.rob_idx);
    endfunction

    function automatic string show_commit(input commit_t c);
        return $sformatf("rd %0d dest %0d old %0d has_dest %0b",
                         c.rd, c.dest_tag, c.old_tag, c.has_dest);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Comparisons
    //////////////////////////////////////////////////////////////////////

    task automatic check_rename();
        rename_result_t exp;
        logic           stall;
        if (rename_q.size() == 0) begin
            $display("%0t: a rename result came out with nothing dispatched for it", $time);
            fails++;
            return;
        end
        exp   = rename_q.pop_front();
        stall = stall_q.pop_front();
        pending--;
        // Slots go out in dispatch order and wrap
        exp.rob_idx = rob_idx_t'(rename_count);
        if (rename_result !== exp) begin
            $display("ERROR %0t: rename %0d got %s, expected %s", $time, rename_count,
                     show_rename(rename_result), show_rename(exp));
            fails++;
        end else if (stall_d !== stall) begin
            $display("ERROR %0t: rename %0d saw ready low %0b, expected %0b",
                     $time, rename_count, stall_d, stall);
            fails++;
        end else begin
            $display("%0t: rename %0d passed", $time, rename_count);
            passes++;
        end
        rename_count++;
    endtask

    task automatic check_commit();
        commit_t exp;
        if (commit_q.size() == 0) begin
            $display("%0t: a commit came out that was never expected", $time);
            fails++;
            return;
        end
        exp = commit_q.pop_front();
        pending--;
        if (commit !== exp) begin
            $display("ERROR %0t: commit %0d got %s, expected %s", $time, commit_count,
                     show_commit(commit), show_commit(exp));
            fails++;
        end else begin
            $display("%0t: commit %0d passed", $time, commit_count);
            passes++;
        end
        commit_count++;
    endtask

    // Falling edge, all DUT outputs and driven inputs are settled here
    always @(negedge clock) begin
        if (!rst_n) begin
            accept_d    = 1'b0;
            stall_seen  = 1'b0;
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                after_reset = 1'b0;
                if (dispatch_ready !== 1'b1) begin
                    $display("ERROR %0t: dispatch_ready %b after reset, expected 1",
                             $time, dispatch_ready);
                    fails++;
                end else begin
                    $display("%0t: reset state passed", $time);
                    passes++;
                end
            end
            // Exactly one cycle after each accepting edge
            if (rename_valid !== accept_d) begin
                $display("ERROR %0t: rename_valid %b, expected %b",
                         $time, rename_valid, accept_d);
                fails++;
            end
            if (rename_valid === 1'b1) begin
                check_rename();
            end
            if (commit_valid === 1'b1) begin
                check_commit();
            end
            // Track back-pressure seen by the dispatch now on the bus
            if (dispatch_valid && !dispatch_ready) begin
                stall_seen = 1'b1;
            end
            accept_d = dispatch_valid && dispatch_ready;
            if (accept_d) begin
                stall_d    = stall_seen;
                stall_seen = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
/* Clock and reset source for the rename core testbench.
   40 ns clock, reset held low over the first four rising edges. */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    localparam int HALF_PERIOD = 20;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Released just after the fourth edge, like any other driven input
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clock);
        #2;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* design/rename_core.sv */
/* Top of the rename and commit core. Accepts one decoded instruction per
   cycle, renames it through the map table and free list, tracks it in the ROB. */

`timescale 1ns/1ps
`default_nettype none

module rename_core import rename_pkg::*; (
    input  logic           clock,
    input  logic           rst_n,

    // Dispatch, valid and ready levels
    input  logic           dispatch_valid,
    input  dispatch_inst_t dispatch_inst,
    output logic           dispatch_ready,

    // Completion strobe from execution
    input  logic           complete_valid,
    input  rob_idx_t       complete_idx,

    // Rename result, one cycle after acceptance
    output logic           rename_valid,
    output rename_result_t rename_result,

    // In-order commit
    output logic           commit_valid,
    output commit_t        commit
);

    logic      accept;
    logic      has_dest;
    logic      alloc_dest;
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    phys_tag_t old_tag;
    phys_tag_t free_tag;
    phys_tag_t dest_tag;
    logic      fl_empty;
    logic      rob_full;
    rob_idx_t  rob_idx;
    commit_t   rob_entry;
    logic      reclaim_valid;
    phys_tag_t reclaim_tag;

    //////////////////////////////////////////////////////////////////////
    // Dispatch control
    //////////////////////////////////////////////////////////////////////

    // x0 is never renamed
    assign has_dest = (dispatch_inst.rd != '0);

    // Free list only matters when a tag is needed
    assign dispatch_ready = !rob_full && !(fl_empty && has_dest);
    assign accept         = dispatch_valid && dispatch_ready;
    assign alloc_dest     = accept && has_dest;

    assign dest_tag = has_dest ? free_tag : '0;

    // What the ROB keeps until retire
    assign rob_entry.rd       = dispatch_inst.rd;
    assign rob_entry.dest_tag = dest_tag;
    assign rob_entry.old_tag  = old_tag;
    assign rob_entry.has_dest = has_dest;

    //////////////////////////////////////////////////////////////////////
    // Rename blocks
    //////////////////////////////////////////////////////////////////////

    map_table map_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .rd_addr1 (dispatch_inst.rs1),
        .rd_tag1  (src1_tag),
        .rd_addr2 (dispatch_inst.rs2),
        .rd_tag2  (src2_tag),
        .old_addr (dispatch_inst.rd),
        .old_tag  (old_tag),
        .wr_en    (alloc_dest),
        .wr_addr  (dispatch_inst.rd),
        .wr_tag   (free_tag)
    );

    free_list free_list_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .alloc         (alloc_dest),
        .head_tag      (free_tag),
        .empty         (fl_empty),
        .reclaim_valid (reclaim_valid),
        .reclaim_tag   (reclaim_tag)
    );

    reorder_buffer rob_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .alloc          (accept),
        .alloc_entry    (rob_entry),
        .alloc_idx      (rob_idx),
        .full           (rob_full),
        .complete_valid (complete_valid),
        .complete_idx   (complete_idx),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .reclaim_valid  (reclaim_valid),
        .reclaim_tag    (reclaim_tag)
    );

    //////////////////////////////////////////////////////////////////////
    // Rename result register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rename_valid <= 1'b0;
        end else begin
            rename_valid <= accept;
        end
    end

    // Payload held until the next accepted instruction
    always_ff @(posedge clock) begin
        if (accept) begin
            rename_result.src1_tag <= src1_tag;
            rename_result.src2_tag <= src2_tag;
            rename_result.dest_tag <= dest_tag;
            rename_result.old_tag  <= old_tag;
            rename_result.has_dest <= has_dest;
            rename_result.rob_idx  <= rob_idx;
        end
    end

endmodule

`default_nettype wire

/* design/reorder_buffer.sv */
/* Circular reorder buffer: allocates at the tail, takes completions by
   index and retires the oldest done slot, one per cycle, in order. */

`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module reorder_buffer import rename_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,

    // Allocate from dispatch
    input  logic      alloc,
    input  commit_t   alloc_entry,
    output rob_idx_t  alloc_idx,
    output logic      full,

    // Completion strobe by slot index
    input  logic      complete_valid,
    input  rob_idx_t  complete_idx,

    // Registered retire record
    output logic      commit_valid,
    output commit_t   commit,

    // Old tag back to the free list at the retire edge
    output logic      reclaim_valid,
    output phys_tag_t reclaim_tag
);

    typedef logic [`RN_ROB_W:0] rob_cnt_t;

    rob_state_t state_q [`RN_ROB_DEPTH];
    commit_t    entry_q [`RN_ROB_DEPTH];
    rob_idx_t   head_q;
    rob_idx_t   tail_q;
    rob_cnt_t   count_q;
    logic       alloc_ok;
    logic       retire;
    commit_t    head_entry;

    // Wrap at the last slot
    function automatic rob_idx_t idx_next(input rob_idx_t idx);
        if (idx == rob_idx_t'(`RN_ROB_DEPTH - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Head and tail decisions
    //////////////////////////////////////////////////////////////////////

    assign full      = (count_q == rob_cnt_t'(`RN_ROB_DEPTH));
    assign alloc_ok  = alloc && !full;
    assign alloc_idx = tail_q;

    // Empty slots are never DONE, so no separate count check
    assign retire     = (state_q[head_q] == ROB_DONE);
    assign head_entry = entry_q[head_q];

    // Reclaim goes out with the retire decision
    // Free list takes it at the same edge
    assign reclaim_valid = retire && head_entry.has_dest;
    assign reclaim_tag   = head_entry.old_tag;

    //////////////////////////////////////////////////////////////////////
    // Slot state and pointers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            commit_valid <= 1'b0;
            for (int i = 0; i < `RN_ROB_DEPTH; i++) begin
                state_q[i] <= ROB_EMPTY;
            end
        end else begin
            commit_valid <= retire;

            // Completion first, so a retiring head still ends EMPTY
            if (complete_valid) begin
                state_q[complete_idx] <= ROB_DONE;
            end
            if (alloc_ok) begin
                state_q[tail_q] <= ROB_WAITING;
                tail_q          <= idx_next(tail_q);
            end
            if (retire) begin
                state_q[head_q] <= ROB_EMPTY;
                head_q          <= idx_next(head_q);
            end

            case ({alloc_ok, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Payload
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (alloc_ok) begin
            entry_q[tail_q] <= alloc_entry;
        end
        // Record shows up one cycle after the retire edge
        if (retire) begin
            commit <= head_entry;
        end
    end

endmodule

`default_nettype wire

/* design/free_list.sv */
/* Circular FIFO of free physical tags. Pops from the head on allocate,
   pushes retired tags at the tail; preloaded with the non-identity tags. */

`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module free_list import rename_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,

    // Allocate side
    input  logic      alloc,
    output phys_tag_t head_tag,
    output logic      empty,

    // Reclaim side, from retire
    input  logic      reclaim_valid,
    input  phys_tag_t reclaim_tag
);

    // Only tags beyond the identity set are ever free
    localparam int FREE_DEPTH = `RN_PHYS_REGS - `RN_ARCH_REGS;
    localparam int PTR_W      = $clog2(FREE_DEPTH);

    typedef logic [PTR_W-1:0] fl_ptr_t;
    typedef logic [PTR_W:0]   fl_cnt_t;

    phys_tag_t tags_q [FREE_DEPTH];
    fl_ptr_t   head_q;
    fl_ptr_t   tail_q;
    fl_cnt_t   count_q;
    logic      pop;
    logic      push;

    // Wrap at the last slot
    function automatic fl_ptr_t ptr_next(input fl_ptr_t ptr);
        if (ptr == fl_ptr_t'(FREE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Pop only when something is there
    assign pop  = alloc && !empty;
    assign push = reclaim_valid;

    //////////////////////////////////////////////////////////////////////
    // Pointers, count and storage
    //////////////////////////////////////////////////////////////////////

    // Tags 32 and up in ascending order after reset
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= fl_cnt_t'(FREE_DEPTH);
            for (int i = 0; i < FREE_DEPTH; i++) begin
                tags_q[i] <= phys_tag_t'(`RN_ARCH_REGS + i);
            end
        end else begin
            if (pop) begin
                head_q <= ptr_next(head_q);
            end
            if (push) begin
                tags_q[tail_q] <= reclaim_tag;
                tail_q         <= ptr_next(tail_q);
            end
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Head visible in the same cycle
    assign head_tag = tags_q[head_q];
    assign empty    = (count_q == '0);

endmodule

`default_nettype wire

/* design/map_table.sv */
/* Speculative map from architectural registers to physical tags.
   Three combinational lookups, one write applied at the clock edge. */

`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module map_table import rename_pkg::*; (
    input  logic      clock,
    input  logic      rst_n,

    // Source operand lookups
    input  arch_reg_t rd_addr1,
    output phys_tag_t rd_tag1,
    input  arch_reg_t rd_addr2,
    output phys_tag_t rd_tag2,

    // Current mapping of the destination, becomes old_tag
    input  arch_reg_t old_addr,
    output phys_tag_t old_tag,

    // New mapping from dispatch
    input  logic      wr_en,
    input  arch_reg_t wr_addr,
    input  phys_tag_t wr_tag
);

    //////////////////////////////////////////////////////////////////////
    // Mapping storage
    //////////////////////////////////////////////////////////////////////

    phys_tag_t map_q [`RN_ARCH_REGS];

    // Identity mapping out of reset, arch i sits in physical i
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
        end else if (wr_en) begin
            map_q[wr_addr] <= wr_tag;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Lookups
    //////////////////////////////////////////////////////////////////////

    // No bypass of the write port
    // Same-cycle readers see the state before this instruction
    assign rd_tag1 = map_q[rd_addr1];
    assign rd_tag2 = map_q[rd_addr2];
    assign old_tag = map_q[old_addr];

endmodule

`default_nettype wire

/* design/rename_pkg.sv */
/* Shared types of the rename core: index vectors, ROB slot state and the
   packed records that move between dispatch, the ROB and commit. */

`default_nettype none

`include "rename_params.svh"

package rename_pkg;

    // Index vectors
    typedef logic [`RN_ARCH_W-1:0] arch_reg_t;
    typedef logic [`RN_PHYS_W-1:0] phys_tag_t;
    typedef logic [`RN_ROB_W-1:0]  rob_idx_t;

    // Life of one ROB slot
    typedef enum logic [1:0] {
        ROB_EMPTY   = 2'd0,
        ROB_WAITING = 2'd1,
        ROB_DONE    = 2'd2
    } rob_state_t;

    // Decoded instruction at dispatch, rd of 0 means no destination
    typedef struct packed {
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
    } dispatch_inst_t;

    // Rename output, one per accepted instruction
    typedef struct packed {
        phys_tag_t src1_tag;
        phys_tag_t src2_tag;
        phys_tag_t dest_tag;
        phys_tag_t old_tag;
        logic      has_dest;
        rob_idx_t  rob_idx;
    } rename_result_t;

    // Retire record, also the payload held in each ROB slot
    typedef struct packed {
        arch_reg_t rd;
        phys_tag_t dest_tag;
        phys_tag_t old_tag;
        logic      has_dest;
    } commit_t;

endpackage

`default_nettype wire

/* design/rename_params.svh */
/* Size macros for the rename and commit core.
   Included by the package and by every RTL file that sizes an array. */

`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Register file sizes
`define RN_ARCH_REGS 32
`define RN_PHYS_REGS 48

// Reorder buffer slots
`define RN_ROB_DEPTH 16

// Index widths, kept in step with the counts above
`define RN_ARCH_W 5
`define RN_PHYS_W 6
`define RN_ROB_W  4

`endif
